// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing -Wno-fatal
TOP      := tb_backend_top
FILELIST := backend_top.f
STIMULUS := testbench/backend_stimulus.txt
LOG      := sim.log

BIN  := obj_dir/V$(TOP)
SRCS := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) $(STIMULUS)
	./$(BIN) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== backend_top.f ====
hdl/backend_pkg.sv
hdl/arch_regfile.sv
hdl/rename_stage.sv
hdl/dispatch_stage.sv
hdl/alu_lane.sv
hdl/reorder_buffer.sv
hdl/backend_top.sv
testbench/tb_backend_top.sv

// ==== hdl/alu_lane.sv ====
`timescale 1ns/100ps

module alu_lane (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue_i,
  input  backend_pkg::renamed_t inst_i,
  output backend_pkg::result_t  result_o
);

  backend_pkg::word_t    op_a;
  backend_pkg::word_t    op_b;
  backend_pkg::word_t    alu_res;
  logic                  valid_q;
  backend_pkg::rob_rid_t rob_id_q;
  backend_pkg::word_t    value_q;

  assign op_a = inst_i.src[0].value;
  assign op_b = inst_i.src[1].value;

  always_comb begin
    case (inst_i.op)
      backend_pkg::ALU_ADD: alu_res = op_a + op_b;
      backend_pkg::ALU_SUB: alu_res = op_a - op_b;
      backend_pkg::ALU_AND: alu_res = op_a & op_b;
      backend_pkg::ALU_OR:  alu_res = op_a | op_b;
      backend_pkg::ALU_XOR: alu_res = op_a ^ op_b;
      backend_pkg::ALU_SLL: alu_res = op_a << op_b[4:0];
      backend_pkg::ALU_SRL: alu_res = op_a >> op_b[4:0];
      // signed compare
      backend_pkg::ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      default:              alu_res = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_i) begin
      rob_id_q <= inst_i.rob_id;
      value_q <= alu_res;
    end
  end

  assign result_o = '{valid: valid_q, rob_id: rob_id_q, value: value_q};

endmodule

// ==== hdl/arch_regfile.sv ====
`timescale 1ns/100ps

module arch_regfile (
  input  logic                         clk,
  input  logic                         rst_n,
  input  backend_pkg::arch_rid_t [3:0] raddr_i,
  output backend_pkg::word_t [3:0]     rdata_o,
  input  backend_pkg::commit_t [1:0]   commit_i
);

  backend_pkg::word_t regs_q [backend_pkg::NUM_ARCH_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < backend_pkg::NUM_ARCH_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (commit_i[c].valid && commit_i[c].rd != '0) begin
          regs_q[commit_i[c].rd] <= commit_i[c].value;
        end
      end
    end
  end

  // write-through, later commit slot overrides
  always_comb begin
    for (int p = 0; p < 4; p++) begin
      rdata_o[p] = regs_q[raddr_i[p]];
      for (int c = 0; c < 2; c++) begin
        if (commit_i[c].valid && commit_i[c].rd == raddr_i[p]) begin
          rdata_o[p] = commit_i[c].value;
        end
      end
      if (raddr_i[p] == '0) begin
        rdata_o[p] = '0;
      end
    end
  end

endmodule

// ==== hdl/backend_pkg.sv ====
package backend_pkg;

  parameter int NUM_ARCH_REGS = 32;
  parameter int ROB_DEPTH = 16;

  typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_rid_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_rid_t;
  // one more bit than an id, holds 0..ROB_DEPTH
  typedef logic [$clog2(ROB_DEPTH):0] rob_cnt_t;
  typedef logic [31:0] word_t;
  typedef logic [11:0] imm_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

  typedef struct packed {
    alu_op_e   op;
    logic      use_imm;
    arch_rid_t rd;
    arch_rid_t rs1;
    arch_rid_t rs2;
    imm_t      imm;
  } inst_t;

  typedef struct packed {
    logic     ready;
    rob_rid_t tag;
    word_t    value;
  } operand_t;

  // src[1] carries the immediate when use_imm is set
  typedef struct packed {
    alu_op_e        op;
    logic           use_imm;
    arch_rid_t      rd;
    rob_rid_t       rob_id;
    operand_t [1:0] src;
  } renamed_t;

  typedef struct packed {
    logic     valid;
    rob_rid_t rob_id;
    word_t    value;
  } result_t;

  typedef struct packed {
    logic      valid;
    arch_rid_t rd;
    word_t     value;
  } commit_t;

endpackage

// ==== hdl/backend_top.sv ====
`timescale 1ns/100ps

module backend_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pkg_valid_i,
  input  logic [1:0]                 pkg_mask_i,
  input  backend_pkg::inst_t [1:0]   pkg_i,
  output logic                       pkg_ready_o,
  output backend_pkg::commit_t [1:0] commit_o
);

  backend_pkg::arch_rid_t [3:0] rf_raddr;
  backend_pkg::word_t [3:0]     rf_rdata;
  backend_pkg::rob_rid_t [1:0]  alloc_id;
  backend_pkg::rob_cnt_t        rob_free;
  logic [1:0]                   alloc;
  backend_pkg::arch_rid_t [1:0] alloc_dest;
  // read ports 0..3 serve dispatch, 4..7 serve rename
  backend_pkg::rob_rid_t [7:0]  rob_tag;
  logic [7:0]                   rob_done;
  backend_pkg::word_t [7:0]     rob_value;
  backend_pkg::commit_t [1:0]   retire;
  backend_pkg::rob_rid_t [1:0]  retire_id;
  logic                         disp_busy;
  backend_pkg::renamed_t [1:0]  renamed;
  logic [1:0]                   renamed_mask;
  logic [1:0]                   issue;
  backend_pkg::renamed_t [1:0]  issue_inst;
  backend_pkg::result_t [1:0]   result;

  assign alloc_dest[0] = pkg_i[0].rd;
  assign alloc_dest[1] = pkg_i[1].rd;
  assign commit_o = retire;

  rename_stage i_rename_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .pkg_valid_i    (pkg_valid_i),
    .pkg_mask_i     (pkg_mask_i),
    .pkg_i          (pkg_i),
    .pkg_ready_o    (pkg_ready_o),
    .rf_raddr_o     (rf_raddr),
    .rf_rdata_i     (rf_rdata),
    .alloc_id_i     (alloc_id),
    .rob_free_i     (rob_free),
    .rob_tag_o      (rob_tag[7:4]),
    .rob_done_i     (rob_done[7:4]),
    .rob_value_i    (rob_value[7:4]),
    .alloc_o        (alloc),
    .retire_i       (retire),
    .retire_id_i    (retire_id),
    .disp_busy_i    (disp_busy),
    .renamed_o      (renamed),
    .renamed_mask_o (renamed_mask)
  );

  arch_regfile i_arch_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .raddr_i  (rf_raddr),
    .rdata_o  (rf_rdata),
    .commit_i (retire)
  );

  dispatch_stage i_dispatch_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .renamed_i      (renamed),
    .renamed_mask_i (renamed_mask),
    .busy_o         (disp_busy),
    .rob_tag_o      (rob_tag[3:0]),
    .rob_done_i     (rob_done[3:0]),
    .rob_value_i    (rob_value[3:0]),
    .result_i       (result),
    .issue_o        (issue),
    .issue_inst_o   (issue_inst)
  );

  for (genvar l = 0; l < 2; l++) begin : g_lane
    alu_lane i_alu_lane (
      .clk      (clk),
      .rst_n    (rst_n),
      .issue_i  (issue[l]),
      .inst_i   (issue_inst[l]),
      .result_o (result[l])
    );
  end

  reorder_buffer i_reorder_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_i      (alloc),
    .alloc_id_o   (alloc_id),
    .free_o       (rob_free),
    .dest_i       (alloc_dest),
    .result_i     (result),
    .read_tag_i   (rob_tag),
    .read_done_o  (rob_done),
    .read_value_o (rob_value),
    .commit_o     (retire),
    .retire_id_o  (retire_id)
  );

endmodule

// ==== hdl/dispatch_stage.sv ====
`timescale 1ns/100ps

module dispatch_stage (
  input  logic                        clk,
  input  logic                        rst_n,
  input  backend_pkg::renamed_t [1:0] renamed_i,
  input  logic [1:0]                  renamed_mask_i,
  output logic                        busy_o,
  output backend_pkg::rob_rid_t [3:0] rob_tag_o,
  input  logic [3:0]                  rob_done_i,
  input  backend_pkg::word_t [3:0]    rob_value_i,
  input  backend_pkg::result_t [1:0]  result_i,
  output logic [1:0]                  issue_o,
  output backend_pkg::renamed_t [1:0] issue_inst_o
);

  backend_pkg::renamed_t [1:0] inst_q;
  logic [1:0]                  pend_q;
  logic [1:0]                  ops_ready;

  for (genvar s = 0; s < 2; s++) begin : g_tag
    assign rob_tag_o[2*s]   = inst_q[s].src[0].tag;
    assign rob_tag_o[2*s+1] = inst_q[s].src[1].tag;
  end

  // fill missing operands from the ROB or the result bus
  always_comb begin
    issue_inst_o = inst_q;
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < 2; k++) begin
        if (!inst_q[s].src[k].ready) begin
          if (rob_done_i[2*s+k]) begin
            issue_inst_o[s].src[k].ready = 1'b1;
            issue_inst_o[s].src[k].value = rob_value_i[2*s+k];
          end
          for (int r = 0; r < 2; r++) begin
            if (result_i[r].valid && result_i[r].rob_id == inst_q[s].src[k].tag) begin
              issue_inst_o[s].src[k].ready = 1'b1;
              issue_inst_o[s].src[k].value = result_i[r].value;
            end
          end
        end
      end
      ops_ready[s] = issue_inst_o[s].src[0].ready && issue_inst_o[s].src[1].ready;
    end
  end

  // in order, slot 1 never passes slot 0
  assign issue_o[0] = pend_q[0] && ops_ready[0];
  assign issue_o[1] = pend_q[1] && ops_ready[1] && (!pend_q[0] || issue_o[0]);
  assign busy_o = |(pend_q & ~issue_o);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= '0;
    end else if (|renamed_mask_i) begin
      pend_q <= renamed_mask_i;
    end else begin
      pend_q <= pend_q & ~issue_o;
    end
  end

  always_ff @(posedge clk) begin
    if (|renamed_mask_i) begin
      inst_q <= renamed_i;
    end else begin
      inst_q <= issue_inst_o;
    end
  end

endmodule

// ==== hdl/rename_stage.sv ====
`timescale 1ns/100ps

module rename_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         pkg_valid_i,
  input  logic [1:0]                   pkg_mask_i,
  input  backend_pkg::inst_t [1:0]     pkg_i,
  output logic                         pkg_ready_o,
  output backend_pkg::arch_rid_t [3:0] rf_raddr_o,
  input  backend_pkg::word_t [3:0]     rf_rdata_i,
  input  backend_pkg::rob_rid_t [1:0]  alloc_id_i,
  input  backend_pkg::rob_cnt_t        rob_free_i,
  output backend_pkg::rob_rid_t [3:0]  rob_tag_o,
  input  logic [3:0]                   rob_done_i,
  input  backend_pkg::word_t [3:0]     rob_value_i,
  output logic [1:0]                   alloc_o,
  input  backend_pkg::commit_t [1:0]   retire_i,
  input  backend_pkg::rob_rid_t [1:0]  retire_id_i,
  input  logic                         disp_busy_i,
  output backend_pkg::renamed_t [1:0]  renamed_o,
  output logic [1:0]                   renamed_mask_o
);

  logic [backend_pkg::NUM_ARCH_REGS-1:0] pending_q;
  backend_pkg::rob_rid_t                 map_id_q [backend_pkg::NUM_ARCH_REGS];
  backend_pkg::operand_t [3:0]           src_op;
  logic                                  take;

  // room for a full pair in the ROB and nothing stuck in dispatch
  assign pkg_ready_o = (rob_free_i >= backend_pkg::rob_cnt_t'(2)) && !disp_busy_i;
  assign take = pkg_valid_i && pkg_ready_o;
  assign alloc_o = {2{take}} & pkg_mask_i;
  assign renamed_mask_o = alloc_o;

  for (genvar s = 0; s < 2; s++) begin : g_slot
    for (genvar k = 0; k < 2; k++) begin : g_src
      localparam int P = 2 * s + k;
      backend_pkg::arch_rid_t areg;
      backend_pkg::operand_t  op;
      logic                   retiring;

      assign areg = (k == 0) ? pkg_i[s].rs1 : pkg_i[s].rs2;
      assign rf_raddr_o[P] = areg;
      assign rob_tag_o[P] = map_id_q[areg];
      // producer on the commit port now, regfile bypass has the value
      assign retiring = (retire_i[0].valid && retire_id_i[0] == map_id_q[areg]) ||
                        (retire_i[1].valid && retire_id_i[1] == map_id_q[areg]);

      always_comb begin
        op.ready = 1'b1;
        op.tag = map_id_q[areg];
        op.value = rf_rdata_i[P];
        if (k == 1 && pkg_i[s].use_imm) begin
          op.value = {{20{pkg_i[s].imm[11]}}, pkg_i[s].imm};
        end else if (s == 1 && pkg_mask_i[0] && pkg_i[0].rd != '0 &&
                     areg == pkg_i[0].rd) begin
          // same-packet dependency on slot 0
          op.ready = 1'b0;
          op.tag = alloc_id_i[0];
        end else if (pending_q[areg] && !retiring) begin
          op.ready = rob_done_i[P];
          op.value = rob_value_i[P];
        end
      end

      assign src_op[P] = op;
    end

    assign renamed_o[s] = '{
      op:      pkg_i[s].op,
      use_imm: pkg_i[s].use_imm,
      rd:      pkg_i[s].rd,
      rob_id:  alloc_id_i[s],
      src:     src_op[2*s+1 -: 2]
    };
  end

  // map table, slot 1 wins on a shared destination
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_q <= '0;
      for (int r = 0; r < backend_pkg::NUM_ARCH_REGS; r++) begin
        map_id_q[r] <= '0;
      end
    end else begin
      for (int r = 0; r < backend_pkg::NUM_ARCH_REGS; r++) begin
        for (int c = 0; c < 2; c++) begin
          if (retire_i[c].valid && pending_q[r] && map_id_q[r] == retire_id_i[c]) begin
            pending_q[r] <= 1'b0;
          end
        end
      end
      for (int s = 0; s < 2; s++) begin
        if (alloc_o[s] && pkg_i[s].rd != '0) begin
          pending_q[pkg_i[s].rd] <= 1'b1;
          map_id_q[pkg_i[s].rd] <= alloc_id_i[s];
        end
      end
    end
  end

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/100ps

module reorder_buffer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [1:0]                   alloc_i,
  output backend_pkg::rob_rid_t [1:0]  alloc_id_o,
  output backend_pkg::rob_cnt_t        free_o,
  input  backend_pkg::arch_rid_t [1:0] dest_i,
  input  backend_pkg::result_t [1:0]   result_i,
  input  backend_pkg::rob_rid_t [7:0]  read_tag_i,
  output logic [7:0]                   read_done_o,
  output backend_pkg::word_t [7:0]     read_value_o,
  output backend_pkg::commit_t [1:0]   commit_o,
  output backend_pkg::rob_rid_t [1:0]  retire_id_o
);

  backend_pkg::rob_rid_t       head_q;
  backend_pkg::rob_rid_t       tail_q;
  backend_pkg::rob_cnt_t       count_q;
  logic [backend_pkg::ROB_DEPTH-1:0] done_q;
  backend_pkg::arch_rid_t      dest_q [backend_pkg::ROB_DEPTH];
  backend_pkg::word_t          value_q [backend_pkg::ROB_DEPTH];
  backend_pkg::rob_rid_t [1:0] head_id;
  logic [1:0]                  retire;
  logic [1:0]                  commit_valid_q;
  backend_pkg::arch_rid_t [1:0] commit_rd_q;
  backend_pkg::word_t [1:0]    commit_value_q;
  backend_pkg::rob_rid_t [1:0] retire_id_q;

  // slot 1 takes the tail when slot 0 is masked off
  assign alloc_id_o[0] = tail_q;
  assign alloc_id_o[1] = alloc_i[0] ? tail_q + 1'b1 : tail_q;
  assign free_o = backend_pkg::rob_cnt_t'(backend_pkg::ROB_DEPTH) - count_q;

  assign head_id[0] = head_q;
  assign head_id[1] = head_q + 1'b1;
  assign retire[0] = (count_q != '0) && done_q[head_id[0]];
  assign retire[1] = retire[0] && (count_q > backend_pkg::rob_cnt_t'(1)) && done_q[head_id[1]];

  for (genvar p = 0; p < 8; p++) begin : g_read
    assign read_done_o[p] = done_q[read_tag_i[p]];
    assign read_value_o[p] = value_q[read_tag_i[p]];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
      done_q <= '0;
      commit_valid_q <= '0;
    end else begin
      head_q <= head_q + backend_pkg::rob_rid_t'(retire[0]) + backend_pkg::rob_rid_t'(retire[1]);
      tail_q <= tail_q + backend_pkg::rob_rid_t'(alloc_i[0]) + backend_pkg::rob_rid_t'(alloc_i[1]);
      count_q <= count_q + backend_pkg::rob_cnt_t'(alloc_i[0])
               + backend_pkg::rob_cnt_t'(alloc_i[1])
               - backend_pkg::rob_cnt_t'(retire[0])
               - backend_pkg::rob_cnt_t'(retire[1]);
      for (int i = 0; i < 2; i++) begin
        if (alloc_i[i]) begin
          done_q[alloc_id_o[i]] <= 1'b0;
        end
      end
      for (int i = 0; i < 2; i++) begin
        if (result_i[i].valid) begin
          done_q[result_i[i].rob_id] <= 1'b1;
        end
      end
      commit_valid_q <= retire;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (alloc_i[i]) begin
        dest_q[alloc_id_o[i]] <= dest_i[i];
      end
      if (result_i[i].valid) begin
        value_q[result_i[i].rob_id] <= result_i[i].value;
      end
      commit_rd_q[i] <= dest_q[head_id[i]];
      commit_value_q[i] <= value_q[head_id[i]];
      retire_id_q[i] <= head_id[i];
    end
  end

  for (genvar i = 0; i < 2; i++) begin : g_commit
    assign commit_o[i] = '{
      valid: commit_valid_q[i],
      rd:    commit_rd_q[i],
      value: commit_value_q[i]
    };
  end
  assign retire_id_o = retire_id_q;

endmodule

// ==== testbench/backend_stimulus.txt ====
# mask | slot 0: op use_imm rd rs1 rs2 imm | slot 1: op use_imm rd rs1 rs2 imm | idle
# all fields hex except idle (decimal); op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt
3  0 1 01 00 00 123  0 1 02 00 00 7ff  0
3  0 1 03 00 00 800  0 1 04 00 00 005  2
3  0 0 05 01 02 000  1 0 06 01 02 000  0
3  2 0 07 01 02 000  3 0 08 01 03 000  0
3  4 0 09 02 03 000  5 0 0a 01 04 000  0
3  6 0 0b 03 04 000  7 0 0c 03 01 000  1
3  7 0 0d 01 03 000  2 1 0e 02 00 0f0  0
3  1 1 0f 01 00 001  5 1 10 02 00 004  0
3  4 1 11 03 00 fff  6 1 12 03 00 01f  0
3  3 1 13 00 00 5a5  7 1 14 04 00 ffb  2
3  0 1 15 00 00 010  0 0 16 15 15 000  0
3  1 0 15 16 15 000  5 0 17 15 04 000  0
1  0 1 18 17 00 001  0 0 00 00 00 000  0
2  0 0 00 00 00 000  0 1 19 18 00 002  0
0  0 1 1a 00 00 333  0 1 1b 00 00 444  1
3  0 1 00 00 00 055  0 0 1a 00 01 000  0
1  4 0 1b 00 1a 000  0 0 00 00 00 000  0
3  0 1 1c 1c 00 001  0 0 1c 1c 1c 000  0
3  0 0 1c 1c 1c 000  1 1 1d 1c 00 001  0
3  5 1 1d 1d 00 002  0 0 1c 1c 1d 000  0
3  4 0 1e 1c 1d 000  7 0 1f 1e 1c 000  0
3  6 1 1e 1e 00 001  3 0 1f 1f 1e 000  0
3  0 0 01 1e 1f 000  1 0 02 01 03 000  0
3  2 0 03 01 02 000  0 0 04 03 03 000  0
3  7 0 05 04 03 000  0 0 06 05 00 000  0
3  5 0 07 06 1c 000  6 0 08 07 1d 000  3
2  0 0 00 00 00 000  0 1 09 08 00 7ff  0
1  1 0 0a 09 00 000  0 0 00 00 00 000  0

// ==== testbench/tb_backend_top.sv ====
`timescale 1ns/100ps

module tb_backend_top;

  localparam int TIMEOUT = 200;

  logic                       clk;
  logic                       rst_n;
  logic                       pkg_valid;
  logic [1:0]                 pkg_mask;
  backend_pkg::inst_t [1:0]   pkg;
  logic                       pkg_ready;
  backend_pkg::commit_t [1:0] commit;

  backend_pkg::commit_t exp_q [$];
  logic [31:0]          ref_regs [32];
  int                   mismatches = 0;
  int                   failures = 0;
  int                   commits = 0;
  int                   slots_taken = 0;
  int                   stall_cycles = 0;
  bit                   timed_out = 0;
  integer               seed = 81925;

  backend_top i_backend_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .pkg_valid_i (pkg_valid),
    .pkg_mask_i  (pkg_mask),
    .pkg_i       (pkg),
    .pkg_ready_o (pkg_ready),
    .commit_o    (commit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic backend_pkg::inst_t make_inst(input logic [11:0] f [6]);
    backend_pkg::inst_t inst;
    inst.op = backend_pkg::alu_op_e'(f[0][2:0]);
    inst.use_imm = f[1][0];
    inst.rd = f[2][4:0];
    inst.rs1 = f[3][4:0];
    inst.rs2 = f[4][4:0];
    inst.imm = f[5];
    return inst;
  endfunction

  // expected result per opcode, slt is signed
  function automatic logic [31:0] compute_expected(input logic [2:0] op,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
    case (op)
      3'd0: return a + b;
      3'd1: return a - b;
      3'd2: return a & b;
      3'd3: return a | b;
      3'd4: return a ^ b;
      3'd5: return a << b[4:0];
      3'd6: return a >> b[4:0];
      default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  // architectural model updated in program order at the take
  task automatic model_slot(input backend_pkg::inst_t inst);
    logic [31:0]          a;
    logic [31:0]          b;
    logic [31:0]          res;
    backend_pkg::commit_t entry;
    a = ref_regs[inst.rs1];
    b = inst.use_imm ? {{20{inst.imm[11]}}, inst.imm} : ref_regs[inst.rs2];
    res = compute_expected(inst.op, a, b);
    if (inst.rd != 5'd0) begin
      ref_regs[inst.rd] = res;
    end
    entry.valid = 1'b1;
    entry.rd = inst.rd;
    entry.value = res;
    exp_q.push_back(entry);
    slots_taken++;
  endtask

  task automatic send_packet(input logic [1:0] mask, input backend_pkg::inst_t i0,
                             input backend_pkg::inst_t i1);
    bit taken;
    int waited;
    taken = 0;
    waited = 0;
    pkg_valid = 1'b1;
    pkg_mask = mask;
    pkg[0] = i0;
    pkg[1] = i1;
    while (!taken && waited < TIMEOUT) begin
      @(negedge clk);
      if (pkg_ready) begin
        taken = 1;
      end else begin
        stall_cycles++;
        waited++;
      end
    end
    if (taken) begin
      if (mask[0]) model_slot(i0);
      if (mask[1]) model_slot(i1);
      @(posedge clk);
      #1;
      pkg_valid = 1'b0;
    end else begin
      failures++;
      timed_out = 1;
      $display("timeout at %0t: packet was never accepted", $time);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  always @(negedge clk) begin : commit_monitor
    backend_pkg::commit_t expected;
    if (rst_n) begin
      for (int c = 0; c < 2; c++) begin
        if (commit[c].valid) begin
          if (exp_q.size() == 0) begin
            failures++;
            $display("unexpected commit on slot %0d at %0t with no instruction pending",
                     c, $time);
          end else begin
            expected = exp_q.pop_front();
            check_value($sformatf("commit %0d rd", commits), {27'b0, commit[c].rd},
                        {27'b0, expected.rd});
            check_value($sformatf("commit %0d value", commits), commit[c].value,
                        expected.value);
          end
          commits++;
        end
      end
    end
  end

  initial begin
    int fd;
    int n;
    int idle;
    int waited;
    string line;
    logic [11:0] fld [13];
    logic [11:0] s0 [6];
    logic [11:0] s1 [6];
    rst_n = 1'b0;
    pkg_valid = 1'b0;
    pkg_mask = 2'b00;
    pkg = '0;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end

    repeat (10) begin
      @(negedge clk);
      check_value("commit valid in reset", {30'b0, commit[1].valid, commit[0].valid}, 0);
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("commit valid after reset", {30'b0, commit[1].valid, commit[0].valid}, 0);

    waited = 0;
    while (!pkg_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!pkg_ready) begin
      failures++;
      timed_out = 1;
      $display("timeout: pkg_ready_o never went high after reset");
    end
    @(posedge clk);
    #1;

    fd = $fopen("testbench/backend_stimulus.txt", "r");
    if (fd == 0) begin
      failures++;
      timed_out = 1;
      $display("could not open the stimulus file");
    end
    while (!timed_out && !$feof(fd)) begin
      line = "";
      n = 0;
      if ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                    fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], idle);
      end
      if (n == 14) begin
        for (int i = 0; i < 6; i++) begin
          s0[i] = fld[1 + i];
          s1[i] = fld[7 + i];
        end
        send_packet(fld[0][1:0], make_inst(s0), make_inst(s1));
        idle_cycles(idle + $unsigned($random(seed)) % 3);
      end else if (n > 0) begin
        failures++;
        $display("malformed stimulus line: %s", line);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    // drain whatever is still in flight
    waited = 0;
    while (!timed_out && exp_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      failures++;
      $display("timeout: %0d instructions never committed", exp_q.size());
    end
    repeat (10) @(negedge clk);
    check_value("commit count", commits, slots_taken);
    check_value("ready dropped at least once", {31'b0, stall_cycles != 0}, 1);

    $display("errors: %0d mismatches, %0d other failures, %0d commits seen",
             mismatches, failures, commits);
    if (mismatches == 0 && failures == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
